/* rtl/ac97_pkg.sv */
package ac97_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Link and datapath widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int SLOT_W       = 20;
	localparam int CODEC_ADDR_W = 7;
	localparam int CODEC_DATA_W = 16;
	localparam int DMA_ADDR_W   = 30;  // Word address
	localparam int DMA_CNT_W    = 16;  // Word count

	localparam int CSR_SEL_W = 4;  // Block select, csr_a[13:10]
	localparam int CSR_OFS_W = 4;  // Register select, csr_a[3:0]

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CSR register offsets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [CSR_OFS_W-1:0] REG_CMD       = 4'd0;
	localparam logic [CSR_OFS_W-1:0] REG_CMD_ADDR  = 4'd1;
	localparam logic [CSR_OFS_W-1:0] REG_CMD_DATA  = 4'd2;
	localparam logic [CSR_OFS_W-1:0] REG_REPLY     = 4'd3;
	localparam logic [CSR_OFS_W-1:0] REG_DMAR_EN   = 4'd4;
	localparam logic [CSR_OFS_W-1:0] REG_DMAR_ADDR = 4'd5;
	localparam logic [CSR_OFS_W-1:0] REG_DMAR_CNT  = 4'd6;
	localparam logic [CSR_OFS_W-1:0] REG_DMAW_EN   = 4'd8;
	localparam logic [CSR_OFS_W-1:0] REG_DMAW_ADDR = 4'd9;
	localparam logic [CSR_OFS_W-1:0] REG_DMAW_CNT  = 4'd10;

endpackage

/* rtl/ac97_frame_sync.sv */
module ac97_frame_sync #(
	parameter int FRAME_CYCLES = 256
) (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic link_en,
	output logic frame_tick
);

	localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_CYCLES - 1);

	logic [CNT_W-1:0] cnt;

	// Counter parks at zero while the link is down
	always_ff @(posedge sys_clk) begin
		if (sys_rst || !link_en) begin
			cnt <= '0;
			frame_tick <= 1'b0;
		end else begin
			if (cnt == CNT_LAST) begin
				cnt <= '0;
				frame_tick <= 1'b1;  // Frame boundary
			end else begin
				cnt <= cnt + 1'b1;
				frame_tick <= 1'b0;
			end
		end
	end

endmodule

/* rtl/ac97_dma_seq.sv */
module ac97_dma_seq (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic                             frame_tick,
	input  logic                             dmar_active,
	input  logic [ac97_pkg::DMA_ADDR_W-1:0]  dmar_addr,
	input  logic                             dmaw_active,
	input  logic [ac97_pkg::DMA_ADDR_W-1:0]  dmaw_addr,
	output logic                             dmar_next,
	output logic                             dmaw_next,
	output logic                             mem_req,
	output logic                             mem_we,
	output logic [ac97_pkg::DMA_ADDR_W-1:0]  mem_addr,
	input  logic                             mem_ack
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_READ  = 2'd1;
	localparam logic [1:0] ST_WRITE = 2'd2;

	logic [1:0] state;
	logic       rd_pend;
	logic       wr_pend;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ST_IDLE;
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			dmar_next <= 1'b0;
			dmaw_next <= 1'b0;
		end else begin
			dmar_next <= 1'b0;
			dmaw_next <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (rd_pend) begin
						if (dmar_active) begin  // Reads first
							mem_req <= 1'b1;
							mem_we <= 1'b0;
							mem_addr <= dmar_addr;
							state <= ST_READ;
						end else begin
							rd_pend <= 1'b0;  // Channel stopped meanwhile
						end
					end else if (wr_pend) begin
						if (dmaw_active) begin
							mem_req <= 1'b1;
							mem_we <= 1'b1;
							mem_addr <= dmaw_addr;
							state <= ST_WRITE;
						end else begin
							wr_pend <= 1'b0;
						end
					end
				end
				ST_READ: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						rd_pend <= 1'b0;
						dmar_next <= dmar_active;
						state <= ST_IDLE;
					end
				end
				ST_WRITE: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						wr_pend <= 1'b0;
						dmaw_next <= dmaw_active;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase

			// A channel still pending drops the extra frame
			if (frame_tick && dmar_active && !rd_pend)
				rd_pend <= 1'b1;
			if (frame_tick && dmaw_active && !wr_pend)
				wr_pend <= 1'b1;
		end
	end

	// Request held steady until the memory takes it
	a_mem_req_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we));

endmodule

/* rtl/ac97_ctlif.sv */
module ac97_ctlif #(
	parameter logic [ac97_pkg::CSR_SEL_W-1:0] CSR_BLOCK = '0
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst,
	input  logic                              frame_tick,
	input  logic [13:0]                       csr_a,
	input  logic                              csr_we,
	input  logic [31:0]                       csr_di,
	output logic [31:0]                       csr_do,
	output logic                              crrequest_irq,
	output logic                              crreply_irq,
	output logic                              dmar_irq,
	output logic                              dmaw_irq,
	output logic                              down_addr_valid,
	output logic [ac97_pkg::SLOT_W-1:0]       down_addr,
	output logic                              down_data_valid,
	output logic [ac97_pkg::SLOT_W-1:0]       down_data,
	input  logic                              up_frame_valid,
	input  logic                              up_addr_valid,
	input  logic                              up_data_valid,
	input  logic [ac97_pkg::SLOT_W-1:0]       up_addr,
	input  logic [ac97_pkg::SLOT_W-1:0]       up_data,
	output logic                              dmar_active,
	output logic [ac97_pkg::DMA_ADDR_W-1:0]   dmar_addr,
	output logic                              dmaw_active,
	output logic [ac97_pkg::DMA_ADDR_W-1:0]   dmaw_addr,
	input  logic                              dmar_next,
	input  logic                              dmaw_next
);

	localparam int ADDR_PAD = ac97_pkg::SLOT_W - 1 - ac97_pkg::CODEC_ADDR_W;
	localparam int DATA_PAD = ac97_pkg::SLOT_W - ac97_pkg::CODEC_DATA_W;
	localparam int CNT_MSB  = ac97_pkg::DMA_CNT_W + 1;

	logic                               request_en;
	logic                               request_write;
	logic [ac97_pkg::CODEC_ADDR_W-1:0]  request_addr;
	logic [ac97_pkg::CODEC_DATA_W-1:0]  request_data;
	logic [ac97_pkg::CODEC_DATA_W-1:0]  reply_data;
	logic                               dmar_en;
	logic                               dmaw_en;
	logic [ac97_pkg::DMA_CNT_W-1:0]     dmar_cnt;
	logic [ac97_pkg::DMA_CNT_W-1:0]     dmaw_cnt;
	logic                               dmar_finished;
	logic                               dmaw_finished;
	logic                               dmar_finished_r;
	logic                               dmaw_finished_r;
	logic                               csr_sel;
	logic [ac97_pkg::CSR_OFS_W-1:0]     csr_ofs;
	logic                               reply_ok;

	assign csr_sel = csr_a[13 -: ac97_pkg::CSR_SEL_W] == CSR_BLOCK;
	assign csr_ofs = csr_a[ac97_pkg::CSR_OFS_W-1:0];
	assign reply_ok = up_frame_valid & up_addr_valid & up_data_valid;

	assign dmar_finished = dmar_cnt == '0;
	assign dmaw_finished = dmaw_cnt == '0;
	assign dmar_active = dmar_en & ~dmar_finished;
	assign dmaw_active = dmaw_en & ~dmaw_finished;

	// Reset high so an idle channel does not pulse on release
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			dmar_finished_r <= 1'b1;
			dmaw_finished_r <= 1'b1;
		end else begin
			dmar_finished_r <= dmar_finished;
			dmaw_finished_r <= dmaw_finished;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
			request_en <= 1'b0;
			request_write <= 1'b0;
			request_addr <= '0;
			request_data <= '0;
			reply_data <= '0;
			down_addr_valid <= 1'b0;
			down_addr <= '0;
			down_data_valid <= 1'b0;
			down_data <= '0;
			dmar_en <= 1'b0;
			dmar_addr <= '0;
			dmar_cnt <= '0;
			dmaw_en <= 1'b0;
			dmaw_addr <= '0;
			dmaw_cnt <= '0;
			crrequest_irq <= 1'b0;
			crreply_irq <= 1'b0;
			dmar_irq <= 1'b0;
			dmaw_irq <= 1'b0;
		end else begin
			crrequest_irq <= 1'b0;
			crreply_irq <= 1'b0;
			dmar_irq <= dmar_finished & ~dmar_finished_r;
			dmaw_irq <= dmaw_finished & ~dmaw_finished_r;

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Frame boundary
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (frame_tick) begin
				down_addr_valid <= request_en;
				down_addr <= {ac97_pkg::SLOT_W{request_en}}
					& {~request_write, request_addr, {ADDR_PAD{1'b0}}};
				down_data_valid <= request_en & request_write;
				down_data <= {ac97_pkg::SLOT_W{request_en & request_write}}
					& {request_data, {DATA_PAD{1'b0}}};
				request_en <= 1'b0;  // Consumed by this frame
				crrequest_irq <= request_en;
				if (reply_ok) begin
					crreply_irq <= 1'b1;
					reply_data <= up_data[ac97_pkg::SLOT_W-1 -: ac97_pkg::CODEC_DATA_W];
				end
			end

			if (dmar_next) begin
				dmar_addr <= dmar_addr + 1'b1;
				dmar_cnt <= dmar_cnt - 1'b1;
			end
			if (dmaw_next) begin
				dmaw_addr <= dmaw_addr + 1'b1;
				dmaw_cnt <= dmaw_cnt - 1'b1;
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// CPU access
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			csr_do <= '0;
			if (csr_sel) begin
				if (csr_we) begin
					case (csr_ofs)
						ac97_pkg::REG_CMD: begin
							request_en <= csr_di[0];
							request_write <= csr_di[1];
						end
						ac97_pkg::REG_CMD_ADDR: request_addr <= csr_di[ac97_pkg::CODEC_ADDR_W-1:0];
						ac97_pkg::REG_CMD_DATA: request_data <= csr_di[ac97_pkg::CODEC_DATA_W-1:0];
						ac97_pkg::REG_DMAR_EN: dmar_en <= csr_di[0];
						ac97_pkg::REG_DMAR_ADDR: dmar_addr <= csr_di[31:2];  // Byte to word
						ac97_pkg::REG_DMAR_CNT: dmar_cnt <= csr_di[CNT_MSB:2];
						ac97_pkg::REG_DMAW_EN: dmaw_en <= csr_di[0];
						ac97_pkg::REG_DMAW_ADDR: dmaw_addr <= csr_di[31:2];
						ac97_pkg::REG_DMAW_CNT: dmaw_cnt <= csr_di[CNT_MSB:2];
						default: ;
					endcase
				end
				case (csr_ofs)
					ac97_pkg::REG_CMD: csr_do <= {30'd0, request_write, request_en};
					ac97_pkg::REG_CMD_ADDR: csr_do <= 32'(request_addr);
					ac97_pkg::REG_CMD_DATA: csr_do <= 32'(request_data);
					ac97_pkg::REG_REPLY: csr_do <= 32'(reply_data);
					ac97_pkg::REG_DMAR_EN: csr_do <= {31'd0, dmar_en};
					ac97_pkg::REG_DMAR_ADDR: csr_do <= {dmar_addr, 2'b00};
					ac97_pkg::REG_DMAR_CNT: csr_do <= 32'({dmar_cnt, 2'b00});
					ac97_pkg::REG_DMAW_EN: csr_do <= {31'd0, dmaw_en};
					ac97_pkg::REG_DMAW_ADDR: csr_do <= {dmaw_addr, 2'b00};
					ac97_pkg::REG_DMAW_CNT: csr_do <= 32'({dmaw_cnt, 2'b00});
					default: csr_do <= '0;
				endcase
			end
		end
	end

	// Sequencer must not step a channel with nothing left to move
	a_dmar_next_active: assert property (@(posedge sys_clk) disable iff (sys_rst)
		dmar_next |-> dmar_active);
	a_dmaw_next_active: assert property (@(posedge sys_clk) disable iff (sys_rst)
		dmaw_next |-> dmaw_active);

endmodule

/* rtl/ac97_ctl_top.sv */
module ac97_ctl_top #(
	parameter logic [ac97_pkg::CSR_SEL_W-1:0] CSR_BLOCK = '0,
	parameter int FRAME_CYCLES = 256
) (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic                             link_en,
	input  logic [13:0]                      csr_a,
	input  logic                             csr_we,
	input  logic [31:0]                      csr_di,
	output logic [31:0]                      csr_do,
	output logic                             crrequest_irq,
	output logic                             crreply_irq,
	output logic                             dmar_irq,
	output logic                             dmaw_irq,
	output logic                             down_addr_valid,
	output logic [ac97_pkg::SLOT_W-1:0]      down_addr,
	output logic                             down_data_valid,
	output logic [ac97_pkg::SLOT_W-1:0]      down_data,
	input  logic                             up_frame_valid,
	input  logic                             up_addr_valid,
	input  logic                             up_data_valid,
	input  logic [ac97_pkg::SLOT_W-1:0]      up_addr,
	input  logic [ac97_pkg::SLOT_W-1:0]      up_data,
	output logic                             mem_req,
	output logic                             mem_we,
	output logic [ac97_pkg::DMA_ADDR_W-1:0]  mem_addr,
	input  logic                             mem_ack
);

	logic                             frame_tick;
	logic                             dmar_active;
	logic                             dmaw_active;
	logic [ac97_pkg::DMA_ADDR_W-1:0]  dmar_addr;
	logic [ac97_pkg::DMA_ADDR_W-1:0]  dmaw_addr;
	logic                             dmar_next;
	logic                             dmaw_next;

	ac97_frame_sync #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) u_frame_sync (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.link_en(link_en),
		.frame_tick(frame_tick)
	);

	ac97_ctlif #(
		.CSR_BLOCK(CSR_BLOCK)
	) u_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.frame_tick(frame_tick),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.crrequest_irq(crrequest_irq),
		.crreply_irq(crreply_irq),
		.dmar_irq(dmar_irq),
		.dmaw_irq(dmaw_irq),
		.down_addr_valid(down_addr_valid),
		.down_addr(down_addr),
		.down_data_valid(down_data_valid),
		.down_data(down_data),
		.up_frame_valid(up_frame_valid),
		.up_addr_valid(up_addr_valid),
		.up_data_valid(up_data_valid),
		.up_addr(up_addr),
		.up_data(up_data),
		.dmar_active(dmar_active),
		.dmar_addr(dmar_addr),
		.dmaw_active(dmaw_active),
		.dmaw_addr(dmaw_addr),
		.dmar_next(dmar_next),
		.dmaw_next(dmaw_next)
	);

	ac97_dma_seq u_dma_seq (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.frame_tick(frame_tick),
		.dmar_active(dmar_active),
		.dmar_addr(dmar_addr),
		.dmaw_active(dmaw_active),
		.dmaw_addr(dmaw_addr),
		.dmar_next(dmar_next),
		.dmaw_next(dmaw_next),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack)
	);

endmodule

/* sim/ac97_checker.sv */
module ac97_checker #(
	parameter logic [ac97_pkg::CSR_SEL_W-1:0] CSR_BLOCK = '0,
	parameter int FRAME_CYCLES = 256
) (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic                             link_en,
	input  logic [13:0]                      csr_a,
	input  logic                             csr_we,
	input  logic [31:0]                      csr_di,
	input  logic [31:0]                      csr_do,
	input  logic                             crrequest_irq,
	input  logic                             crreply_irq,
	input  logic                             dmar_irq,
	input  logic                             dmaw_irq,
	input  logic                             down_addr_valid,
	input  logic [ac97_pkg::SLOT_W-1:0]      down_addr,
	input  logic                             down_data_valid,
	input  logic [ac97_pkg::SLOT_W-1:0]      down_data,
	input  logic                             up_frame_valid,
	input  logic                             up_addr_valid,
	input  logic                             up_data_valid,
	input  logic [ac97_pkg::SLOT_W-1:0]      up_data,
	input  logic                             mem_req,
	input  logic                             mem_we,
	input  logic [ac97_pkg::DMA_ADDR_W-1:0]  mem_addr,
	input  logic                             mem_ack,
	output int                               err_cnt
);

	int checks;
	int rd_xfers;
	int wr_xfers;
	int fcnt;
	logic tick;
	logic req_en;
	logic req_wr;
	logic [ac97_pkg::CODEC_ADDR_W-1:0] req_addr;
	logic [ac97_pkg::CODEC_DATA_W-1:0] req_data;
	logic [ac97_pkg::CODEC_DATA_W-1:0] reply;
	logic rd_en;
	logic wr_en;
	logic [ac97_pkg::DMA_ADDR_W-1:0] rd_addr;
	logic [ac97_pkg::DMA_ADDR_W-1:0] wr_addr;
	logic [ac97_pkg::DMA_CNT_W-1:0] rd_cnt;
	logic [ac97_pkg::DMA_CNT_W-1:0] wr_cnt;
	logic rd_fin_r;
	logic wr_fin_r;
	logic rd_step;
	logic wr_step;
	logic prev_wait;
	logic prev_we;
	logic [ac97_pkg::DMA_ADDR_W-1:0] prev_addr;
	logic [31:0] e_do;
	logic e_crq;
	logic e_crp;
	logic e_rirq;
	logic e_wirq;
	logic e_dav;
	logic e_ddv;
	logic [ac97_pkg::SLOT_W-1:0] e_da;
	logic [ac97_pkg::SLOT_W-1:0] e_dd;

	initial err_cnt = 0;

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
		end
	endtask

	task automatic report_fault(input string what);
		err_cnt++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic report();
		$display("checks %0d, errors %0d, memory reads %0d, memory writes %0d",
			checks, err_cnt, rd_xfers, wr_xfers);
	endtask

	function automatic logic [31:0] reg_value(input logic [ac97_pkg::CSR_OFS_W-1:0] ofs);
		case (ofs)
			ac97_pkg::REG_CMD: return {30'd0, req_wr, req_en};
			ac97_pkg::REG_CMD_ADDR: return 32'(req_addr);
			ac97_pkg::REG_CMD_DATA: return 32'(req_data);
			ac97_pkg::REG_REPLY: return 32'(reply);
			ac97_pkg::REG_DMAR_EN: return 32'(rd_en);
			ac97_pkg::REG_DMAR_ADDR: return {rd_addr, 2'b00};
			ac97_pkg::REG_DMAR_CNT: return 32'(rd_cnt) << 2;  // Bytes
			ac97_pkg::REG_DMAW_EN: return 32'(wr_en);
			ac97_pkg::REG_DMAW_ADDR: return {wr_addr, 2'b00};
			ac97_pkg::REG_DMAW_CNT: return 32'(wr_cnt) << 2;
			default: return '0;
		endcase
	endfunction

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			{fcnt, tick, req_en, req_wr, req_addr, req_data, reply} = '0;
			{rd_en, wr_en, rd_addr, wr_addr, rd_cnt, wr_cnt, rd_step, wr_step} = '0;
			rd_fin_r = 1'b1;  // Idle channel after reset is already finished
			wr_fin_r = 1'b1;
			{prev_wait, prev_we, prev_addr, e_do, e_crq, e_crp, e_rirq, e_wirq} = '0;
			{e_dav, e_ddv, e_da, e_dd} = '0;
		end else begin
			check_value("csr_do", e_do, csr_do);
			check_value("crrequest_irq", 32'(e_crq), 32'(crrequest_irq));
			check_value("crreply_irq", 32'(e_crp), 32'(crreply_irq));
			check_value("dmar_irq", 32'(e_rirq), 32'(dmar_irq));
			check_value("dmaw_irq", 32'(e_wirq), 32'(dmaw_irq));
			check_value("down_addr_valid", 32'(e_dav), 32'(down_addr_valid));
			check_value("down_addr", 32'(e_da), 32'(down_addr));
			check_value("down_data_valid", 32'(e_ddv), 32'(down_data_valid));
			check_value("down_data", 32'(e_dd), 32'(down_data));

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Memory port
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (prev_wait) begin
				if (!mem_req)
					report_fault("memory request dropped before mem_ack");
				check_value("mem_addr", 32'(prev_addr), 32'(mem_addr));
				check_value("mem_we", 32'(prev_we), 32'(mem_we));
			end
			prev_wait = mem_req && !mem_ack;
			prev_addr = mem_addr;
			prev_we = mem_we;

			e_do = (csr_a[13:10] == CSR_BLOCK) ? reg_value(csr_a[3:0]) : '0;
			e_rirq = (rd_cnt == 0) && !rd_fin_r;
			e_wirq = (wr_cnt == 0) && !wr_fin_r;
			rd_fin_r = rd_cnt == 0;
			wr_fin_r = wr_cnt == 0;

			e_crq = 1'b0;
			e_crp = 1'b0;
			if (tick) begin
				e_dav = req_en;
				e_da = req_en ? {~req_wr, req_addr, 12'd0} : '0;
				e_ddv = req_en && req_wr;
				e_dd = e_ddv ? {req_data, 4'd0} : '0;
				e_crq = req_en;
				req_en = 1'b0;
				if (up_frame_valid && up_addr_valid && up_data_valid) begin
					e_crp = 1'b1;
					reply = up_data[19:4];
				end
			end
			tick = link_en && (fcnt == FRAME_CYCLES - 1);
			fcnt = (!link_en || tick) ? 0 : fcnt + 1;

			if (rd_step) begin  // Step lands a cycle after the ack
				rd_addr = rd_addr + 1'b1;
				rd_cnt = rd_cnt - 1'b1;
			end
			if (wr_step) begin
				wr_addr = wr_addr + 1'b1;
				wr_cnt = wr_cnt - 1'b1;
			end
			rd_step = 1'b0;
			wr_step = 1'b0;
			if (mem_req && mem_ack) begin
				if (mem_we) begin
					wr_xfers++;
					if (!wr_en || wr_cnt == 0)
						report_fault("memory write while the capture channel is idle");
					check_value("mem_addr", 32'(wr_addr), 32'(mem_addr));
					wr_step = wr_en && wr_cnt != 0;
				end else begin
					rd_xfers++;
					if (!rd_en || rd_cnt == 0)
						report_fault("memory read while the playback channel is idle");
					check_value("mem_addr", 32'(rd_addr), 32'(mem_addr));
					rd_step = rd_en && rd_cnt != 0;
				end
			end

			if (csr_a[13:10] == CSR_BLOCK && csr_we) begin
				case (csr_a[3:0])
					ac97_pkg::REG_CMD: begin
						req_en = csr_di[0];
						req_wr = csr_di[1];
					end
					ac97_pkg::REG_CMD_ADDR: req_addr = csr_di[6:0];
					ac97_pkg::REG_CMD_DATA: req_data = csr_di[15:0];
					ac97_pkg::REG_DMAR_EN: rd_en = csr_di[0];
					ac97_pkg::REG_DMAR_ADDR: rd_addr = csr_di[31:2];
					ac97_pkg::REG_DMAR_CNT: rd_cnt = csr_di[ac97_pkg::DMA_CNT_W+1:2];
					ac97_pkg::REG_DMAW_EN: wr_en = csr_di[0];
					ac97_pkg::REG_DMAW_ADDR: wr_addr = csr_di[31:2];
					ac97_pkg::REG_DMAW_CNT: wr_cnt = csr_di[ac97_pkg::DMA_CNT_W+1:2];
					default: ;
				endcase
			end
		end
	end

endmodule

/* sim/tb_ac97.sv */
module tb_ac97;

	localparam int FRAME_CYCLES = 16;
	localparam int RUN_LIMIT = 40 * FRAME_CYCLES * 10 + 3000;

	logic sys_clk;
	logic sys_rst;
	logic link_en;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic crrequest_irq;
	logic crreply_irq;
	logic dmar_irq;
	logic dmaw_irq;
	logic down_addr_valid;
	logic down_data_valid;
	logic [ac97_pkg::SLOT_W-1:0] down_addr;
	logic [ac97_pkg::SLOT_W-1:0] down_data;
	logic up_frame_valid;
	logic up_addr_valid;
	logic up_data_valid;
	logic [ac97_pkg::SLOT_W-1:0] up_addr;
	logic [ac97_pkg::SLOT_W-1:0] up_data;
	logic mem_req;
	logic mem_we;
	logic mem_ack;
	logic [ac97_pkg::DMA_ADDR_W-1:0] mem_addr;
	int err_cnt;
	int ack_wait;
	int phase;

	ac97_ctl_top #(.CSR_BLOCK(4'd2), .FRAME_CYCLES(FRAME_CYCLES)) dut (.*);

	ac97_checker #(.CSR_BLOCK(4'd2), .FRAME_CYCLES(FRAME_CYCLES)) chk (.*);

	always #5 sys_clk = ~sys_clk;

	task automatic csr_access(input logic [3:0] blk, input logic [3:0] ofs, input logic we,
		input logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= {blk, 6'd0, ofs};
		csr_we <= we;
		csr_di <= data;
	endtask

	task automatic csr_write(input logic [3:0] ofs, input logic [31:0] data);
		csr_access(4'd2, ofs, 1'b1, data);
		csr_access(4'd0, 4'd0, 1'b0, '0);  // Bus idle
	endtask

	task automatic csr_read(input logic [3:0] ofs);
		csr_access(4'd2, ofs, 1'b0, $urandom);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory responder and codec
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge sys_clk) begin
		if (sys_rst) begin
			mem_ack <= 1'b0;
			ack_wait <= 0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
			ack_wait <= $urandom % 6;
		end else if (mem_req) begin
			if (ack_wait == 0)
				mem_ack <= 1'b1;
			else
				ack_wait <= ack_wait - 1;
		end
	end

	always @(posedge sys_clk) begin
		if (!link_en)
			phase <= 0;
		else
			phase <= (phase == FRAME_CYCLES - 1) ? 0 : phase + 1;
		if (link_en && phase == FRAME_CYCLES / 2) begin  // Mid-frame, clear of the strobe
			up_frame_valid <= ($urandom % 4) != 0;
			up_addr_valid <= ($urandom % 4) != 0;
			up_data_valid <= ($urandom % 4) != 0;
			up_addr <= 20'($urandom);
			up_data <= 20'($urandom);
		end
	end

	initial begin
		#(RUN_LIMIT);
		$display("Timeout: DMA or codec traffic did not finish in %0d time units", RUN_LIMIT);
		chk.report();
		$display("Checks failed");
		$finish;
	end

	initial begin
		int n;
		void'($urandom(39));
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		link_en = 1'b0;
		{csr_a, csr_we, csr_di} = '0;
		{up_frame_valid, up_addr_valid, up_data_valid, up_addr, up_data} = '0;
		mem_ack = 1'b0;
		phase = 0;
		repeat (2) @(posedge sys_clk);
		sys_rst <= 1'b0;

		for (int i = 0; i < 16; i++)
			csr_read(4'(i));  // All zero after reset
		for (int i = 0; i < 16; i++) begin
			csr_write(4'(i), $urandom);
			csr_read(4'(i));
		end
		repeat (40)
			csr_access(($urandom % 4 == 0) ? 4'($urandom) : 4'd2, 4'($urandom), 1'($urandom),
				$urandom);
		csr_write(ac97_pkg::REG_CMD, '0);
		csr_write(ac97_pkg::REG_DMAR_EN, '0);
		csr_write(ac97_pkg::REG_DMAW_EN, '0);
		csr_write(ac97_pkg::REG_DMAR_CNT, '0);
		csr_write(ac97_pkg::REG_DMAW_CNT, '0);

		link_en <= 1'b1;
		for (int i = 0; i < 2; i++) begin
			csr_write(ac97_pkg::REG_CMD_ADDR, $urandom);
			csr_write(ac97_pkg::REG_CMD_DATA, $urandom);
			csr_write(ac97_pkg::REG_CMD, {30'd0, i == 0, 1'b1});  // Write, then read
			do @(posedge sys_clk); while (!crrequest_irq);
			repeat (2 * FRAME_CYCLES) @(posedge sys_clk);
			csr_read(ac97_pkg::REG_CMD);
		end
		repeat (2) begin
			do @(posedge sys_clk); while (!crreply_irq);
			csr_read(ac97_pkg::REG_REPLY);
		end

		n = 3 + $urandom % 4;
		csr_write(ac97_pkg::REG_DMAR_ADDR, $urandom);
		csr_write(ac97_pkg::REG_DMAR_CNT, 32'(n * 4));
		csr_write(ac97_pkg::REG_DMAR_EN, 32'd1);
		do @(posedge sys_clk); while (!dmar_irq);
		csr_read(ac97_pkg::REG_DMAR_CNT);
		csr_read(ac97_pkg::REG_DMAR_ADDR);

		// Both channels under random back-pressure
		csr_write(ac97_pkg::REG_DMAR_ADDR, $urandom);
		csr_write(ac97_pkg::REG_DMAW_ADDR, $urandom);
		csr_write(ac97_pkg::REG_DMAW_CNT, 32'((4 + $urandom % 3) * 4));
		csr_write(ac97_pkg::REG_DMAW_EN, 32'd1);
		csr_write(ac97_pkg::REG_DMAR_CNT, 32'((3 + $urandom % 3) * 4));
		fork
			do @(posedge sys_clk); while (!dmar_irq);
			do @(posedge sys_clk); while (!dmaw_irq);
		join
		csr_read(ac97_pkg::REG_DMAR_CNT);
		csr_read(ac97_pkg::REG_DMAR_ADDR);
		csr_read(ac97_pkg::REG_DMAW_CNT);
		csr_read(ac97_pkg::REG_DMAW_ADDR);
		repeat (4) @(posedge sys_clk);

		chk.report();
		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sources.f */
rtl/ac97_pkg.sv
rtl/ac97_frame_sync.sv
rtl/ac97_dma_seq.sv
rtl/ac97_ctlif.sv
rtl/ac97_ctl_top.sv
sim/ac97_checker.sv
sim/tb_ac97.sv
